//--- sources.f
+incdir+dv
verilog/pm_pkg.sv
verilog/rail_controller.sv
verilog/sample_gate.sv
verilog/sample_fifo.sv
verilog/thermal_monitor.sv
verilog/pm_top.sv
dv/pm_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the power-management testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module pm_tb -f sources.f -o pm_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pm_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result comes from the testbench's own verdict line
if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

//--- dv/pm_model.svh
/* Reference model of rail decode, sample filtering and thermal hysteresis.
   Included inside the testbench module */
`ifndef PM_MODEL_SVH
`define PM_MODEL_SVH

pm_pkg::rails_t model_rails;
logic [15:0]    model_cons;
logic [7:0]     model_limits;
logic [11:0]    model_temp [3];  // digital, analog, dac
logic           model_warn;
logic           model_shut;

// ==============================
// Thresholds
// ==============================
function automatic logic [11:0] warn_level(input logic [7:0] lim);
    return {pm_pkg::WARN_BASE, lim} + pm_pkg::WARN_OFFSET;
endfunction

function automatic logic [11:0] shut_level(input logic [7:0] lim);
    return {pm_pkg::SHUT_BASE, lim} + pm_pkg::SHUT_OFFSET;
endfunction

// Regulation setting to current code
function automatic logic [3:0] reg_code(input logic [2:0] sel);
    if (sel == 3'd0) return pm_pkg::CUR_HIGH;
    if (sel == 3'd2) return pm_pkg::CUR_LOW;
    return pm_pkg::CUR_MED;  // Setting 1 and anything above 2
endfunction

function automatic logic [7:0] expected_status();
    return {model_shut, model_warn, model_cons > pm_pkg::HIGH_CURRENT_LIMIT,
            model_rails.class_a, model_rails.pll, model_rails.dac,
            model_rails.analog, model_rails.digital};
endfunction

task automatic model_reset();
    model_rails  = '0;
    model_cons   = '0;
    model_limits = '0;
    model_temp   = '{12'h000, 12'h000, 12'h000};
    model_warn   = 1'b0;
    model_shut   = 1'b0;
endtask

// Hysteresis on the hottest stored reading
task automatic model_evaluate();
    logic [11:0] hottest;
    int          i;
    hottest = model_temp[0];
    for (i = 1; i < 3; i++) begin
        if (model_temp[i] > hottest) hottest = model_temp[i];
    end
    if (hottest > warn_level(model_limits)) model_warn = 1'b1;
    else if (hottest < warn_level(model_limits) - pm_pkg::HYST) model_warn = 1'b0;
    if (hottest > shut_level(model_limits)) model_shut = 1'b1;
    else if (hottest < shut_level(model_limits) - pm_pkg::HYST) model_shut = 1'b0;
endtask

task automatic model_configure(input logic pe, input pm_pkg::pm_config_t c);
    logic [3:0] code;
    code = reg_code(c.ldo_settings[2:0]);
    model_rails.digital = pe;
    model_rails.analog  = pe;
    model_rails.dac     = pe & c.power_mode[0];
    model_rails.pll     = pe & c.power_mode[1];
    model_rails.class_a = pe & c.power_mode[2];
    model_cons = {model_rails.pll ? code : 4'h0,
                  model_rails.dac ? pm_pkg::CUR_ULTRA : 4'h0,
                  model_rails.analog ? code : 4'h0,
                  model_rails.digital ? code : 4'h0};
    model_limits = c.thermal_limits;
    model_evaluate();  // Idle monitor re-evaluates with new limits
endtask

// One accepted input transfer
task automatic model_take(input pm_pkg::temp_sample_t s);
    case (s.sensor)
        pm_pkg::SENSOR_DIGITAL: if (model_rails.digital) model_temp[0] = s.temp;
        pm_pkg::SENSOR_ANALOG:  if (model_rails.analog) model_temp[1] = s.temp;
        pm_pkg::SENSOR_DAC:     if (model_rails.dac) model_temp[2] = s.temp;
        default:                model_temp[2] = model_temp[2];  // Reserved, dropped
    endcase
    model_evaluate();
endtask

`endif

//--- dv/pm_tb.sv
/* Testbench for the power-management top level. Seeded random config and
   sample bursts, compared against the included reference model */
module pm_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int NUM_RANDOM     = 16;
    localparam int NUM_PHASES     = NUM_RANDOM + 3;  // Plus reset and two drop phases
    localparam int BURST_LEN      = 24;
    localparam int TIMEOUT_CYCLES = NUM_PHASES * (BURST_LEN * 4 + 40);
    localparam int DRAIN_CYCLES   = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 power_enable;
    pm_pkg::pm_config_t   cfg;
    logic                 in_valid;
    pm_pkg::temp_sample_t in_sample;
    logic                 in_ready;
    pm_pkg::rails_t       rails;
    logic [15:0]          current_consumption;
    logic                 thermal_warning;
    logic                 thermal_shutdown;
    logic [7:0]           status_flags;

    integer seed;
    int     errors       = 0;
    int     checks       = 0;
    int     cycles       = 0;
    int     quiet_cycles = 0;  // Cycles with in_ready high and no transfer

    `include "pm_model.svh"

    pm_top DUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .power_enable        (power_enable),
        .cfg                 (cfg),
        .in_valid            (in_valid),
        .in_sample           (in_sample),
        .in_ready            (in_ready),
        .rails               (rails),
        .current_consumption (current_consumption),
        .thermal_warning     (thermal_warning),
        .thermal_shutdown    (thermal_shutdown),
        .status_flags        (status_flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // ==============================
    // Transfer tracking, timeout
    // ==============================
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (rst_n && in_valid && in_ready) begin
            model_take(in_sample);
            quiet_cycles = 0;
        end else if (!in_ready) begin
            quiet_cycles = 0;
        end else begin
            quiet_cycles = quiet_cycles + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    // Temperature near the warning or shutdown level, or well below both
    function automatic logic [11:0] pick_temp(input int kind, input logic [11:0] r);
        case (kind)
            0:       return warn_level(model_limits) - 12'h030 + {6'h00, r[5:0]};
            1:       return shut_level(model_limits) - 12'h030 + {6'h00, r[5:0]};
            default: return {2'b00, r[9:0]};
        endcase
    endfunction

    task automatic apply_config(input string name, input logic pe,
                                input pm_pkg::pm_config_t c);
        logic [7:0] exp_status;
        @(posedge clk);
        power_enable <= pe;
        cfg          <= c;
        model_configure(pe, c);
        repeat (2) @(posedge clk);
        @(negedge clk);
        exp_status = expected_status();
        check_value({name, " rails"}, 32'(model_rails), 32'(rails));
        check_value({name, " current"}, 32'(model_cons), 32'(current_consumption));
        check_value({name, " status low"}, 32'(exp_status[5:0]), 32'(status_flags[5:0]));
    endtask

    // Called and left on a rising edge
    task automatic send_sample(input pm_pkg::temp_sample_t s);
        in_valid  <= 1'b1;
        in_sample <= s;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic send_burst(input int kind, input int n);
        pm_pkg::temp_sample_t s;
        logic [31:0]          r;
        logic                 dense;
        int                   gap;
        int                   i;
        r     = next_random();
        dense = r[0];  // Few gaps, fills the FIFO
        @(posedge clk);
        for (i = 0; i < n; i++) begin
            r        = next_random();
            s.sensor = pm_pkg::sensor_e'(r[1:0]);
            s.temp   = pick_temp(kind, r[31:20]);
            gap      = dense ? int'(r[4:2] == 3'd0) : int'(r[3:2]);
            repeat (gap) @(posedge clk);
            send_sample(s);
        end
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (quiet_cycles < DRAIN_CYCLES) @(negedge clk);
    endtask

    task automatic check_thermal(input string name);
        logic [7:0] exp_status;
        exp_status = expected_status();
        check_value({name, " warning"}, 32'(model_warn), 32'(thermal_warning));
        check_value({name, " shutdown"}, 32'(model_shut), 32'(thermal_shutdown));
        check_value({name, " status"}, 32'(exp_status), 32'(status_flags));
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        pm_pkg::pm_config_t   c;
        pm_pkg::temp_sample_t s;
        logic [31:0]          r;
        int                   phase;
        int                   kind;
        seed         = 32'h64bc_1e7f;
        rst_n        = 1'b0;
        power_enable = 1'b0;
        cfg          = '0;
        in_valid     = 1'b0;
        in_sample    = '0;
        model_reset();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset rails", 32'h0, 32'(rails));
        check_value("reset current", 32'h0, 32'(current_consumption));
        check_value("reset warning", 32'h0, 32'(thermal_warning));
        check_value("reset shutdown", 32'h0, 32'(thermal_shutdown));
        check_value("reset status", 32'h0, 32'(status_flags));
        check_value("reset in_ready", 32'h1, 32'(in_ready));

        // Hot DAC and reserved samples with the DAC rail off
        c = '0;
        apply_config("drop_dac", 1'b1, c);
        @(posedge clk);
        s.temp   = 12'hFFF;
        s.sensor = pm_pkg::SENSOR_DAC;
        send_sample(s);
        s.sensor = pm_pkg::SENSOR_RESERVED;
        send_sample(s);
        wait_drain();
        check_value("drop_dac warning", 32'h0, 32'(thermal_warning));
        check_thermal("drop_dac");

        // Every rail down
        apply_config("drop_off", 1'b0, c);
        @(posedge clk);
        s.sensor = pm_pkg::SENSOR_DIGITAL;
        send_sample(s);
        s.sensor = pm_pkg::SENSOR_ANALOG;
        send_sample(s);
        wait_drain();
        check_thermal("drop_off");

        // Kind 2 changes only the limits, right after a shutdown-level burst
        for (phase = 0; phase < NUM_RANDOM; phase++) begin
            r                = next_random();
            c.power_mode     = r[7:0];
            c.ldo_settings   = r[15:8];
            c.thermal_limits = r[23:16];
            kind             = phase % 4;
            apply_config($sformatf("phase%0d", phase), r[25:24] != 2'b00, c);
            if (kind != 2) begin
                send_burst(kind, 4 + int'(r[30:26]) % (BURST_LEN - 3));
            end
            wait_drain();
            check_thermal($sformatf("phase%0d", phase));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/pm_top.sv
/* Top level of the power-management controller. Connects rail control
   with the sample gate, FIFO and thermal monitor chain */
module pm_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 power_enable,
    input  pm_pkg::pm_config_t   cfg,
    input  logic                 in_valid,
    input  pm_pkg::temp_sample_t in_sample,
    output logic                 in_ready,
    output pm_pkg::rails_t       rails,
    output logic [15:0]          current_consumption,
    output logic                 thermal_warning,
    output logic                 thermal_shutdown,
    output logic [7:0]           status_flags
);

    logic                 gate_valid;
    logic                 gate_ready;
    pm_pkg::temp_sample_t gate_sample;
    logic                 buf_valid;
    logic                 buf_ready;
    pm_pkg::temp_sample_t buf_sample;

    // ==============================
    // Rails and status
    // ==============================
    rail_controller u_rail_controller (
        .clk                 (clk),
        .rst_n               (rst_n),
        .power_enable        (power_enable),
        .cfg                 (cfg),
        .thermal_warning     (thermal_warning),
        .thermal_shutdown    (thermal_shutdown),
        .rails               (rails),
        .current_consumption (current_consumption),
        .status_flags        (status_flags)
    );

    // ==============================
    // Sample chain
    // ==============================
    sample_gate u_sample_gate (
        .clk         (clk),
        .rst_n       (rst_n),
        .rails       (rails),          // Registered rails filter the stream
        .in_valid    (in_valid),
        .in_sample   (in_sample),
        .gate_ready  (gate_ready),
        .in_ready    (in_ready),
        .gate_valid  (gate_valid),
        .gate_sample (gate_sample)
    );

    sample_fifo u_sample_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .gate_valid  (gate_valid),
        .gate_sample (gate_sample),
        .buf_ready   (buf_ready),
        .gate_ready  (gate_ready),
        .buf_valid   (buf_valid),
        .buf_sample  (buf_sample)
    );

    thermal_monitor u_thermal_monitor (
        .clk              (clk),
        .rst_n            (rst_n),
        .thermal_limits   (cfg.thermal_limits),
        .buf_valid        (buf_valid),
        .buf_sample       (buf_sample),
        .buf_ready        (buf_ready),
        .thermal_warning  (thermal_warning),
        .thermal_shutdown (thermal_shutdown)
    );

endmodule

//--- verilog/thermal_monitor.sv
/* Consumer stage: keeps the last reading of each sensor and drives the
   warning and shutdown flags with hysteresis on the hottest one */
module thermal_monitor (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [pm_pkg::CFG_W-1:0] thermal_limits,
    input  logic                     buf_valid,
    input  pm_pkg::temp_sample_t     buf_sample,
    output logic                     buf_ready,
    output logic                     thermal_warning,
    output logic                     thermal_shutdown
);

    pm_pkg::monitor_state_e       state;
    pm_pkg::monitor_state_e       state_next;
    pm_pkg::temp_sample_t         hold;         // Sample taken from the FIFO
    logic [pm_pkg::TEMP_W-1:0]    temp_digital;
    logic [pm_pkg::TEMP_W-1:0]    temp_analog;
    logic [pm_pkg::TEMP_W-1:0]    temp_dac;
    logic [pm_pkg::TEMP_W-1:0]    max_temp;
    logic [pm_pkg::TEMP_W-1:0]    warn_thr;
    logic [pm_pkg::TEMP_W-1:0]    shut_thr;
    logic [pm_pkg::TEMP_W-1:0]    warn_clr;
    logic [pm_pkg::TEMP_W-1:0]    shut_clr;
    logic                         eval_en;

    // ==============================
    // Thresholds and maximum
    // ==============================
    assign warn_thr = {pm_pkg::WARN_BASE, thermal_limits} + pm_pkg::WARN_OFFSET;
    assign shut_thr = {pm_pkg::SHUT_BASE, thermal_limits} + pm_pkg::SHUT_OFFSET;
    assign warn_clr = warn_thr - pm_pkg::HYST;
    assign shut_clr = shut_thr - pm_pkg::HYST;

    always_comb begin
        max_temp = temp_digital;
        if (temp_analog > max_temp) begin
            max_temp = temp_analog;
        end
        if (temp_dac > max_temp) begin
            max_temp = temp_dac;
        end
    end

    // ==============================
    // FSM
    // ==============================
    assign buf_ready = state == pm_pkg::MON_IDLE;
    assign eval_en   = (state == pm_pkg::MON_IDLE) || (state == pm_pkg::MON_EVAL);

    always_comb begin
        case (state)
            pm_pkg::MON_IDLE:  state_next = buf_valid ? pm_pkg::MON_STORE : pm_pkg::MON_IDLE;
            pm_pkg::MON_STORE: state_next = pm_pkg::MON_EVAL;
            default:           state_next = pm_pkg::MON_IDLE;  // EVAL back to idle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= pm_pkg::MON_IDLE;
            temp_digital     <= '0;
            temp_analog      <= '0;
            temp_dac         <= '0;
            thermal_warning  <= 1'b0;
            thermal_shutdown <= 1'b0;
        end else begin
            state <= state_next;
            if (state == pm_pkg::MON_STORE) begin
                case (hold.sensor)
                    pm_pkg::SENSOR_DIGITAL: temp_digital <= hold.temp;
                    pm_pkg::SENSOR_ANALOG:  temp_analog  <= hold.temp;
                    pm_pkg::SENSOR_DAC:     temp_dac     <= hold.temp;
                    default:                temp_dac     <= temp_dac;  // Reserved, ignore
                endcase
            end
            // Hysteresis, flags hold inside the band
            if (eval_en) begin
                if (max_temp > warn_thr) begin
                    thermal_warning <= 1'b1;
                end else if (max_temp < warn_clr) begin
                    thermal_warning <= 1'b0;
                end
                if (max_temp > shut_thr) begin
                    thermal_shutdown <= 1'b1;
                end else if (max_temp < shut_clr) begin
                    thermal_shutdown <= 1'b0;
                end
            end
        end
    end

    // Capture on transfer, FIFO head may move on
    always_ff @(posedge clk) begin
        if (buf_valid && buf_ready) begin
            hold <= buf_sample;
        end
    end

    // Below the shutdown band, the flag is gone by the next edge
    assert property (@(posedge clk) disable iff (!rst_n)
        eval_en && (max_temp < shut_clr) |=> !thermal_shutdown)
        else $error("thermal_shutdown high below its clear level");

endmodule

//--- verilog/sample_fifo.sv
/* Circular buffer of FIFO_DEPTH gated samples between the gate and the
   thermal monitor. Push and pop may happen in the same cycle */
module sample_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 gate_valid,
    input  pm_pkg::temp_sample_t gate_sample,
    input  logic                 buf_ready,
    output logic                 gate_ready,
    output logic                 buf_valid,
    output pm_pkg::temp_sample_t buf_sample
);

    pm_pkg::temp_sample_t            mem [pm_pkg::FIFO_DEPTH];
    logic [pm_pkg::FIFO_PTR_W-1:0]   wr_ptr;
    logic [pm_pkg::FIFO_PTR_W-1:0]   rd_ptr;
    logic [pm_pkg::FIFO_CNT_W-1:0]   count;
    logic                            push;
    logic                            pop;
    logic                            full;
    logic                            empty;

    assign full  = count == pm_pkg::FIFO_CNT_W'(pm_pkg::FIFO_DEPTH);
    assign empty = count == '0;

    assign gate_ready = !full;   // Back-pressure to the gate
    assign buf_valid  = !empty;
    assign buf_sample = mem[rd_ptr];  // Head of queue

    assign push = gate_valid && gate_ready;
    assign pop  = buf_valid && buf_ready;

    // ==============================
    // Pointers and occupancy
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == pm_pkg::FIFO_PTR_W'(pm_pkg::FIFO_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == pm_pkg::FIFO_PTR_W'(pm_pkg::FIFO_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= gate_sample;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("push into full sample FIFO");

    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("pop from empty sample FIFO");

endmodule

//--- verilog/sample_gate.sv
/* Producer stage: one-entry register slice for incoming temperature samples.
   Samples from reserved or unpowered sensors are taken and dropped */
module sample_gate (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pm_pkg::rails_t       rails,
    input  logic                 in_valid,
    input  pm_pkg::temp_sample_t in_sample,
    input  logic                 gate_ready,
    output logic                 in_ready,
    output logic                 gate_valid,
    output pm_pkg::temp_sample_t gate_sample
);

    logic keep;  // Sensor known and its rail on

    always_comb begin
        case (in_sample.sensor)
            pm_pkg::SENSOR_DIGITAL: keep = rails.digital;
            pm_pkg::SENSOR_ANALOG:  keep = rails.analog;
            pm_pkg::SENSOR_DAC:     keep = rails.dac;
            default:                keep = 1'b0;  // Reserved id never passes
        endcase
    end

    // Free slot, or the held sample leaves this cycle
    assign in_ready = !gate_valid || gate_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate_valid <= 1'b0;
        end else if (in_ready) begin
            gate_valid <= in_valid && keep;  // Dropped samples leave the slot empty
        end
    end

    // Payload, loaded only for kept samples
    always_ff @(posedge clk) begin
        if (in_valid && in_ready && keep) begin
            gate_sample <= in_sample;
        end
    end

    // Stalled output stays put until the FIFO takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        gate_valid && !gate_ready |=> gate_valid && $stable(gate_sample))
        else $error("gate sample changed while stalled");

endmodule

//--- verilog/rail_controller.sv
/* Rail enables, regulator current codes and status word, all registered
   one cycle after power_enable or cfg changes */
module rail_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               power_enable,
    input  pm_pkg::pm_config_t cfg,
    input  logic               thermal_warning,
    input  logic               thermal_shutdown,
    output pm_pkg::rails_t     rails,
    output logic [15:0]        current_consumption,
    output logic [7:0]         status_flags
);

    pm_pkg::rails_t               rails_d;
    logic [pm_pkg::CUR_W-1:0]     cur_digital;
    logic [pm_pkg::CUR_W-1:0]     cur_analog;
    logic [pm_pkg::CUR_W-1:0]     cur_dac;
    logic [pm_pkg::CUR_W-1:0]     cur_pll;
    logic [15:0]                  cons_d;
    logic                         high_cur;
    logic [pm_pkg::NUM_RAILS-1:0] rail_bits;  // Status order, digital at bit 0

    // Regulation setting to current code, zero while the rail is off
    function automatic logic [pm_pkg::CUR_W-1:0] ldo_code(
        input logic       en,
        input logic [2:0] sel
    );
        logic [pm_pkg::CUR_W-1:0] code;
        case (sel)
            3'd0:    code = pm_pkg::CUR_HIGH;
            3'd1:    code = pm_pkg::CUR_MED;
            3'd2:    code = pm_pkg::CUR_LOW;
            default: code = pm_pkg::CUR_MED;  // 3..7 fall back to medium
        endcase
        return en ? code : '0;
    endfunction

    // ==============================
    // Rail decode
    // ==============================
    always_comb begin
        rails_d.digital = power_enable;
        rails_d.analog  = power_enable;
        rails_d.dac     = power_enable & cfg.power_mode[0];
        rails_d.pll     = power_enable & cfg.power_mode[1];
        rails_d.class_a = power_enable & cfg.power_mode[2];  // Mode bit only, no bias logic
    end

    assign cur_digital = ldo_code(rails_d.digital, cfg.ldo_settings[2:0]);
    assign cur_analog  = ldo_code(rails_d.analog, cfg.ldo_settings[2:0]);
    assign cur_pll     = ldo_code(rails_d.pll, cfg.ldo_settings[2:0]);
    assign cur_dac     = rails_d.dac ? pm_pkg::CUR_ULTRA : '0;

    assign cons_d    = {cur_pll, cur_dac, cur_analog, cur_digital};  // PLL in top nibble
    assign high_cur  = cons_d > pm_pkg::HIGH_CURRENT_LIMIT;
    assign rail_bits = {rails_d.class_a, rails_d.pll, rails_d.dac,
                        rails_d.analog, rails_d.digital};

    // ==============================
    // Output registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rails               <= '0;
            current_consumption <= '0;
            status_flags        <= '0;
        end else begin
            rails               <= rails_d;
            current_consumption <= cons_d;
            // Thermal bits lag the monitor flags by one cycle
            status_flags        <= {thermal_shutdown, thermal_warning, high_cur, rail_bits};
        end
    end

    // A regulator only draws current while its rail is up
    assert property (@(posedge clk) disable iff (!rst_n)
        (current_consumption[3:0] == '0 || rails.digital) &&
        (current_consumption[7:4] == '0 || rails.analog) &&
        (current_consumption[11:8] == '0 || rails.dac) &&
        (current_consumption[15:12] == '0 || rails.pll))
        else $error("current code reported on a rail that is off");

endmodule

//--- verilog/pm_pkg.sv
/* Shared widths, thermal and current constants, enums and structs of the
   power-management controller. Modules refer to them as pm_pkg::name */
package pm_pkg;

    // ==============================
    // Widths and counts
    // ==============================
    localparam int TEMP_W     = 12;                      // Temperature reading
    localparam int CFG_W      = 8;                       // One config byte
    localparam int CUR_W      = 4;                       // One current-monitor code
    localparam int NUM_RAILS  = 5;                       // digital, analog, dac, pll, class_a
    localparam int FIFO_DEPTH = 4;                       // Sample buffer entries
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);      // Read/write pointer
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // Occupancy, 0..DEPTH

    // ==============================
    // Thermal constants
    // ==============================
    // Threshold = {BASE, limit byte} + OFFSET
    localparam logic [TEMP_W-CFG_W-1:0] WARN_BASE   = 4'h8;
    localparam logic [TEMP_W-1:0]       WARN_OFFSET = 12'h200;
    localparam logic [TEMP_W-1:0]       SHUT_OFFSET = 12'h400;
    localparam logic [TEMP_W-CFG_W-1:0] SHUT_BASE   = 4'hA;
    localparam logic [TEMP_W-1:0]       HYST        = 12'h020;  // Band below each threshold

    // ==============================
    // Current-monitor codes
    // ==============================
    localparam logic [CUR_W-1:0] CUR_HIGH  = 4'hE;  // ldo setting 0
    localparam logic [CUR_W-1:0] CUR_MED   = 4'hC;  // ldo setting 1 and default
    localparam logic [CUR_W-1:0] CUR_LOW   = 4'hA;  // ldo setting 2
    localparam logic [CUR_W-1:0] CUR_ULTRA = 4'hF;  // DAC regulator, fixed
    localparam logic [4*CUR_W-1:0] HIGH_CURRENT_LIMIT = 16'h8000;

    // Sensor id carried with each sample
    typedef enum logic [1:0] {
        SENSOR_DIGITAL  = 2'd0,
        SENSOR_ANALOG   = 2'd1,
        SENSOR_DAC      = 2'd2,
        SENSOR_RESERVED = 2'd3
    } sensor_e;

    // Thermal consumer FSM
    typedef enum logic [1:0] {
        MON_IDLE  = 2'd0,
        MON_STORE = 2'd1,
        MON_EVAL  = 2'd2
    } monitor_state_e;

    typedef struct packed {
        logic [CFG_W-1:0] power_mode;      // bit0 DAC, bit1 PLL, bit2 class-A
        logic [CFG_W-1:0] ldo_settings;    // bits 2..0 select regulation
        logic [CFG_W-1:0] thermal_limits;  // Low byte of both thresholds
    } pm_config_t;

    typedef struct packed {
        logic digital;
        logic analog;
        logic dac;
        logic pll;
        logic class_a;
    } rails_t;

    typedef struct packed {
        sensor_e           sensor;
        logic [TEMP_W-1:0] temp;
    } temp_sample_t;

endpackage
